// ==== verilog/handwrite_defines.svh ====
`ifndef HANDWRITE_DEFINES_SVH
`define HANDWRITE_DEFINES_SVH

// canvas side and area in pixels
`define CANVAS_DIM 30
`define CANVAS_BITS 900

// coarse tiles, 3 by 3 over the canvas
`define TILE_DIM 10
`define TILE_NUM 9

`define PIXEL_W 8
// also the histogram fifo depth
`define STREAM_CREDITS 4

`endif

// ==== verilog/handwrite_pkg.sv ====
`include "handwrite_defines.svh"

package handwrite_pkg;

    // cursor position, 0 to 29
    typedef logic [4:0] coord_t;
    // mouse movement report, two's complement
    typedef logic signed [8:0] delta_t;
    // 255 for ink, 0 for blank
    typedef logic [`PIXEL_W-1:0] pixel_t;
    // bit index is row * 30 + col
    typedef logic [`CANVAS_BITS-1:0] canvas_t;
    typedef logic [3:0] tile_idx_t;
    // at most 100 ink pixels per tile
    typedef logic [6:0] tile_count_t;
    typedef logic [2:0] credit_t;

    typedef enum logic {IDLE, STREAM} ser_state_t;
    typedef enum logic {ACCUM, REPORT} hist_state_t;

endpackage

// ==== verilog/pixel_stream_if.sv ====
`timescale 1ns/1ps

interface pixel_stream_if;
    import handwrite_pkg::*;

    // forward path, one pixel per valid
    logic   valid;
    pixel_t pixel;
    // marks the final pixel of a frame
    logic   last;
    // one pulse per fifo pop in the sink
    logic   credit_return;

    modport source (
        output valid, pixel, last,
        input  credit_return
    );

    modport sink (
        input  valid, pixel, last,
        output credit_return
    );

endinterface

// ==== verilog/stroke_canvas.sv ====
`timescale 1ns/1ps
`include "handwrite_defines.svh"

module stroke_canvas (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_mouse_valid,
    input  handwrite_pkg::delta_t  i_move_x,
    input  handwrite_pkg::delta_t  i_move_y,
    input  logic                   i_btn_left,
    input  logic                   i_btn_right,
    output handwrite_pkg::canvas_t o_canvas
);
    import handwrite_pkg::*;

    localparam int IDX_W = $clog2(`CANVAS_BITS);

    coord_t            cur_x;
    coord_t            cur_y;
    coord_t            next_x;
    coord_t            next_y;
    logic [IDX_W-1:0]  ink_idx;
    canvas_t           canvas;

    // old position plus delta, held inside 0 .. CANVAS_DIM-1
    function automatic coord_t clamp_step(input coord_t pos, input delta_t step);
        logic signed [9:0] sum;
        sum = $signed({5'b0, pos}) + step;
        if (sum < 0)
            clamp_step = '0;
        else if (sum > (`CANVAS_DIM - 1))
            clamp_step = coord_t'(`CANVAS_DIM - 1);
        else
            clamp_step = sum[4:0];
    endfunction

    assign next_x = clamp_step(cur_x, i_move_x);
    assign next_y = clamp_step(cur_y, i_move_y);

    // row major, y picks the row
    assign ink_idx = IDX_W'(next_y) * IDX_W'(`CANVAS_DIM) + IDX_W'(next_x);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            cur_x  <= '0;
            cur_y  <= '0;
            canvas <= '0;
        end else if (i_mouse_valid) begin
            if (i_btn_right) begin
                // wipe everything, cursor holds still
                canvas <= '0;
            end else begin
                cur_x <= next_x;
                cur_y <= next_y;
                // ink lands under the new cursor
                if (i_btn_left)
                    canvas[ink_idx] <= 1'b1;
            end
        end
    end

    assign o_canvas = canvas;

endmodule

// ==== verilog/pixel_serializer.sv ====
`timescale 1ns/1ps
`include "handwrite_defines.svh"

module pixel_serializer (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_start,
    input  handwrite_pkg::canvas_t i_canvas,
    output logic                   o_busy,
    pixel_stream_if.source         o_stream
);
    import handwrite_pkg::*;

    localparam int IDX_W = $clog2(`CANVAS_BITS);

    ser_state_t       state;
    canvas_t          snap;
    logic [IDX_W-1:0] pix_idx;
    credit_t          credit_cnt;
    logic             send;

    // only send while credits remain
    assign send = (state == STREAM) && (credit_cnt != '0);

    assign o_stream.valid = send;
    assign o_stream.pixel = snap[pix_idx] ? '1 : '0;
    assign o_stream.last  = send && (pix_idx == IDX_W'(`CANVAS_BITS - 1));
    assign o_busy         = (state == STREAM);

    // private frame copy, drawing may go on meanwhile
    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_start)
            snap <= i_canvas;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state   <= IDLE;
            pix_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // start while busy falls through here unseen
                    if (i_start) begin
                        state   <= STREAM;
                        pix_idx <= '0;
                    end
                end
                STREAM: begin
                    if (send) begin
                        if (o_stream.last)
                            state <= IDLE;
                        else
                            pix_idx <= pix_idx + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // returned credits in, sent pixels out, both in one cycle
    always_ff @(posedge i_clk) begin
        if (!i_rst_n)
            credit_cnt <= credit_t'(`STREAM_CREDITS);
        else if (o_stream.credit_return && !send)
            credit_cnt <= credit_cnt + 1'b1;
        else if (!o_stream.credit_return && send)
            credit_cnt <= credit_cnt - 1'b1;
    end

endmodule

// ==== verilog/tile_histogram.sv ====
`timescale 1ns/1ps
`include "handwrite_defines.svh"

module tile_histogram (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_tile_ready,
    pixel_stream_if.sink               i_stream,
    output logic                       o_tile_valid,
    output handwrite_pkg::tile_idx_t   o_tile_idx,
    output handwrite_pkg::tile_count_t o_tile_count
);
    import handwrite_pkg::*;

    localparam int DEPTH = `STREAM_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int TILES_PER_ROW = `CANVAS_DIM / `TILE_DIM;

    // fifo storage, pixel plus last flag
    pixel_t            fifo_pixel [DEPTH];
    logic              fifo_last  [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    credit_t           fifo_cnt;
    logic              pop;
    pixel_t            pop_pixel;
    logic              pop_last;

    hist_state_t       state;
    coord_t            row;
    coord_t            col;
    tile_idx_t         pop_tile;
    tile_idx_t         tile_idx;
    tile_count_t       tile_cnt [`TILE_NUM];

    // which band of tiles a row or column falls in
    function automatic logic [1:0] tile_band(input coord_t pos);
        if (pos < `TILE_DIM)
            tile_band = 2'd0;
        else if (pos < 2 * `TILE_DIM)
            tile_band = 2'd1;
        else
            tile_band = 2'd2;
    endfunction

    // popping stops in REPORT so credits dry up upstream
    assign pop       = (state == ACCUM) && (fifo_cnt != '0);
    assign pop_pixel = fifo_pixel[rd_ptr];
    assign pop_last  = fifo_last[rd_ptr];
    assign i_stream.credit_return = pop;

    always_ff @(posedge i_clk) begin
        if (i_stream.valid) begin
            fifo_pixel[wr_ptr] <= i_stream.pixel;
            fifo_last[wr_ptr]  <= i_stream.last;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (i_stream.valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (i_stream.valid && !pop)
                fifo_cnt <= fifo_cnt + 1'b1;
            else if (!i_stream.valid && pop)
                fifo_cnt <= fifo_cnt - 1'b1;
        end
    end

    // tile = row band * 3 + column band
    assign pop_tile = tile_idx_t'(tile_band(row)) * tile_idx_t'(TILES_PER_ROW)
                    + tile_idx_t'(tile_band(col));

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state    <= ACCUM;
            row      <= '0;
            col      <= '0;
            tile_idx <= '0;
            tile_cnt <= '{default: '0};
        end else begin
            case (state)
                ACCUM: begin
                    if (pop) begin
                        if (pop_pixel != '0)
                            tile_cnt[pop_tile] <= tile_cnt[pop_tile] + 1'b1;
                        // frame done, rewind position for the next one
                        if (pop_last) begin
                            state    <= REPORT;
                            row      <= '0;
                            col      <= '0;
                            tile_idx <= '0;
                        end else if (col == coord_t'(`CANVAS_DIM - 1)) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                REPORT: begin
                    // advance only on a transfer
                    if (i_tile_ready) begin
                        if (tile_idx == tile_idx_t'(`TILE_NUM - 1)) begin
                            state    <= ACCUM;
                            tile_cnt <= '{default: '0};
                        end else begin
                            tile_idx <= tile_idx + 1'b1;
                        end
                    end
                end
                default: state <= ACCUM;
            endcase
        end
    end

    assign o_tile_valid = (state == REPORT);
    assign o_tile_idx   = tile_idx;
    assign o_tile_count = tile_cnt[tile_idx];

endmodule

// ==== verilog/handwrite_frontend.sv ====
`timescale 1ns/1ps

module handwrite_frontend (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    // mouse report
    input  logic                       i_mouse_valid,
    input  handwrite_pkg::delta_t      i_move_x,
    input  handwrite_pkg::delta_t      i_move_y,
    input  logic                       i_btn_left,
    input  logic                       i_btn_right,
    input  logic                       i_start,
    output logic                       o_busy,
    // tile results, valid/ready
    output logic                       o_tile_valid,
    output handwrite_pkg::tile_idx_t   o_tile_idx,
    output handwrite_pkg::tile_count_t o_tile_count,
    input  logic                       i_tile_ready
);
    import handwrite_pkg::*;

    canvas_t canvas;

    // credited stream, serializer to histogram
    pixel_stream_if u_stream ();

    stroke_canvas u_canvas (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_mouse_valid (i_mouse_valid),
        .i_move_x      (i_move_x),
        .i_move_y      (i_move_y),
        .i_btn_left    (i_btn_left),
        .i_btn_right   (i_btn_right),
        .o_canvas      (canvas)
    );

    pixel_serializer u_serializer (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_canvas (canvas),
        .o_busy   (o_busy),
        .o_stream (u_stream.source)
    );

    tile_histogram u_histogram (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_tile_ready (i_tile_ready),
        .i_stream     (u_stream.sink),
        .o_tile_valid (o_tile_valid),
        .o_tile_idx   (o_tile_idx),
        .o_tile_count (o_tile_count)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD = 20
) (
    output logic o_clk
);
    // free running, starts low
    initial o_clk = 1'b0;

    always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

// ==== tests/handwrite_frontend_sva.sv ====
`timescale 1ns/1ps
`include "handwrite_defines.svh"

module handwrite_frontend_sva (
    input logic                       i_clk,
    input logic                       i_rst_n,
    input logic                       i_valid,
    input logic                       i_credit_return,
    input logic                       i_tile_valid,
    input handwrite_pkg::tile_idx_t   i_tile_idx,
    input handwrite_pkg::tile_count_t i_tile_count,
    input logic                       i_tile_ready
);
    // shadow of the source credit count, one bit wider to see overflow
    logic [3:0] credits;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n)
            credits <= 4'(`STREAM_CREDITS);
        else if (i_credit_return && !i_valid)
            credits <= credits + 4'd1;
        else if (!i_credit_return && i_valid)
            credits <= credits - 4'd1;
    end

    // no pixel without a credit in hand
    a_valid_needs_credit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> credits != 4'd0)
        else $error("stream valid asserted with no credit left");

    a_credit_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        credits <= 4'(`STREAM_CREDITS))
        else $error("credit count above fifo depth");

    // stalled result holds still
    a_tile_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_tile_valid && !i_tile_ready |=> $stable(i_tile_idx) && $stable(i_tile_count))
        else $error("tile result changed while stalled");

    a_reset_valid_low: assert property (@(posedge i_clk)
        !i_rst_n |=> !i_tile_valid)
        else $error("tile valid high right after reset");

endmodule

// ==== tests/tb_handwrite_frontend.sv ====
`timescale 1ns/1ps
`include "handwrite_defines.svh"

module tb_handwrite_frontend;
    import handwrite_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS = 6;
    // one frame of pixels plus credit and ready stalls
    localparam int FRAME_LIMIT = `CANVAS_BITS + 600;
    // at most four frames in any test
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS * 4 * FRAME_LIMIT * CLK_PERIOD);

    logic        clk;
    logic        rst_n;
    logic        mouse_valid;
    logic        btn_left;
    logic        btn_right;
    logic        start;
    logic        busy;
    logic        tile_valid;
    logic        tile_ready;
    delta_t      move_x;
    delta_t      move_y;
    tile_idx_t   tile_idx;
    tile_count_t tile_count;

    // reference model
    int cur_x;
    int cur_y;
    bit model_canvas [`CANVAS_BITS];
    // nine expected counts per accepted start, oldest set first
    int exp_queue [$];
    int errors;
    int err_base;
    int tests_failed;
    int starts_accepted;
    // frames the serializer actually took, seen on o_busy
    int frames_started;
    bit busy_seen;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_clk (.o_clk(clk));

    handwrite_frontend u_handwrite_frontend (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_mouse_valid (mouse_valid),
        .i_move_x      (move_x),
        .i_move_y      (move_y),
        .i_btn_left    (btn_left),
        .i_btn_right   (btn_right),
        .i_start       (start),
        .o_busy        (busy),
        .o_tile_valid  (tile_valid),
        .o_tile_idx    (tile_idx),
        .o_tile_count  (tile_count),
        .i_tile_ready  (tile_ready)
    );

    bind handwrite_frontend handwrite_frontend_sva u_sva (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_valid         (u_stream.valid),
        .i_credit_return (u_stream.credit_return),
        .i_tile_valid    (o_tile_valid),
        .i_tile_idx      (o_tile_idx),
        .i_tile_count    (o_tile_count),
        .i_tile_ready    (i_tile_ready)
    );

    // a rise of o_busy marks one frame taken
    always @(negedge clk) begin
        if (busy && !busy_seen)
            frames_started++;
        busy_seen = busy;
    end

    function automatic int clamp_coord(input int pos);
        if (pos < 0)
            return 0;
        if (pos > `CANVAS_DIM - 1)
            return `CANVAS_DIM - 1;
        return pos;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else begin
            $display("[ERROR] time %0t: %s expected %0d actual %0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // drive slot, 2 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
        mouse_valid = 1'b0;
        start = 1'b0;
    endtask

    task automatic drive_report(input int dx, input int dy, input bit left, input bit right);
        mouse_valid = 1'b1;
        move_x = delta_t'(dx);
        move_y = delta_t'(dy);
        btn_left = left;
        btn_right = right;
        // right button wipes, cursor stays put
        if (right) begin
            foreach (model_canvas[i])
                model_canvas[i] = 1'b0;
        end else begin
            cur_x = clamp_coord(cur_x + dx);
            cur_y = clamp_coord(cur_y + dy);
            if (left)
                model_canvas[cur_y * `CANVAS_DIM + cur_x] = 1'b1;
        end
    endtask

    task automatic draw_random(input int n, input int step, input int clear_pct);
        int dx, dy;
        for (int k = 0; k < n; k++) begin
            next_cycle();
            dx = int'($urandom_range(2 * step)) - step;
            dy = int'($urandom_range(2 * step)) - step;
            // roughly one cycle in four stays quiet
            if ($urandom_range(3) != 0)
                drive_report(dx, dy, $urandom_range(99) < 70,
                             $urandom_range(99) < clear_pct);
        end
        next_cycle();
    endtask

    task automatic start_frame(input bit after_report);
        int counts [`TILE_NUM];
        // serializer idle, and the previous set drained unless overlapping
        while (busy || (after_report && tile_valid))
            @(negedge clk);
        next_cycle();
        start = 1'b1;
        starts_accepted++;
        // expected tiles from the snapshot, tile = row band * 3 + col band
        foreach (counts[t])
            counts[t] = 0;
        for (int r = 0; r < `CANVAS_DIM; r++) begin
            for (int c = 0; c < `CANVAS_DIM; c++) begin
                if (model_canvas[r * `CANVAS_DIM + c])
                    counts[(r / `TILE_DIM) * 3 + c / `TILE_DIM]++;
            end
        end
        foreach (counts[t])
            exp_queue.push_back(counts[t]);
        next_cycle();
        check_value("o_busy", 1, busy);
    endtask

    task automatic collect_results(input bit random_ready);
        int got, cycles;
        int expected;
        got = 0;
        cycles = 0;
        while (got < `TILE_NUM && cycles < FRAME_LIMIT) begin
            @(posedge clk);
            #2;
            tile_ready = random_ready ? ($urandom_range(99) < 40) : 1'b1;
            // sample mid cycle, transfer lands on the next edge
            @(negedge clk);
            cycles++;
            if (tile_valid && tile_ready) begin
                expected = exp_queue.pop_front();
                check_value("o_tile_idx", got, tile_idx);
                check_value("o_tile_count", expected, tile_count);
                got++;
            end
        end
        assert (got == `TILE_NUM)
        else begin
            $display("[ERROR] time %0t: only %0d of %0d tiles arrived in %0d cycles",
                     $time, got, `TILE_NUM, cycles);
            errors++;
        end
        // rest of a short set is dropped so the next set lines up
        repeat (`TILE_NUM - got)
            exp_queue.delete(0);
        @(posedge clk);
        #2;
        tile_ready = 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (errors == err_base) begin
            $display("[TEST] %s done, no errors", name);
        end else begin
            tests_failed++;
            $display("[TEST] %s done, %0d errors", name, errors - err_base);
        end
        err_base = errors;
    endtask

    initial begin
        bit extra;
        void'($urandom(32'h649f));
        rst_n = 1'b0;
        mouse_valid = 1'b0;
        move_x = '0;
        move_y = '0;
        btn_left = 1'b0;
        btn_right = 1'b0;
        start = 1'b0;
        tile_ready = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // idle outputs, then a blank frame
        @(negedge clk);
        check_value("o_busy", 0, busy);
        check_value("o_tile_valid", 0, tile_valid);
        start_frame(1'b1);
        collect_results(1'b0);
        finish_test("reset_blank");

        repeat (3) begin
            draw_random(60, 3, 5);
            start_frame(1'b1);
            collect_results(1'b0);
        end
        finish_test("random_strokes");

        // drive into each corner from far outside
        next_cycle();
        drive_report(-256, -256, 1'b1, 1'b0);
        next_cycle();
        drive_report(255, 0, 1'b1, 1'b0);
        next_cycle();
        drive_report(0, 255, 1'b1, 1'b0);
        next_cycle();
        drive_report(-256, 0, 1'b1, 1'b0);
        draw_random(40, 255, 0);
        start_frame(1'b1);
        collect_results(1'b0);
        finish_test("edge_clamp");

        draw_random(40, 4, 0);
        next_cycle();
        drive_report(int'($urandom_range(10)) - 5, 3, 1'b1, 1'b1);
        next_cycle();
        start_frame(1'b1);
        collect_results(1'b0);
        draw_random(40, 4, 0);
        start_frame(1'b1);
        collect_results(1'b0);
        finish_test("clear_redraw");

        repeat (2) begin
            draw_random(80, 5, 3);
            start_frame(1'b1);
            // strokes while the first frame streams out
            draw_random(40, 5, 3);
            // second frame queues behind the report until credits run out
            start_frame(1'b0);
            repeat (12)
                next_cycle();
            collect_results(1'b1);
            collect_results(1'b1);
        end
        finish_test("ready_stall");

        draw_random(30, 3, 0);
        start_frame(1'b1);
        // extra starts and strokes while the frame streams out
        repeat (40) begin
            next_cycle();
            if (busy)
                start = ($urandom_range(1) == 1);
            drive_report(int'($urandom_range(6)) - 3, int'($urandom_range(6)) - 3,
                         1'b1, $urandom_range(9) == 0);
        end
        next_cycle();
        collect_results(1'b0);
        extra = 1'b0;
        repeat (64) begin
            @(negedge clk);
            if (busy || tile_valid)
                extra = 1'b1;
        end
        assert (!extra)
        else begin
            $display("[ERROR] time %0t: a new frame began without a start while idle", $time);
            errors++;
        end
        check_value("frames started", starts_accepted, frames_started);
        finish_test("busy_start");

        $display("summary: %0d tests, %0d failed, %0d errors, %0d frames",
                 NUM_TESTS, tests_failed, errors, frames_started);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== handwrite_frontend.f ====
+incdir+verilog
verilog/handwrite_pkg.sv
verilog/pixel_stream_if.sv
verilog/stroke_canvas.sv
verilog/pixel_serializer.sv
verilog/tile_histogram.sv
verilog/handwrite_frontend.sv
tests/tb_clock_gen.sv
tests/handwrite_frontend_sva.sv
tests/tb_handwrite_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the handwriting front end regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f handwrite_frontend.f \
    --top-module tb_handwrite_frontend \
    -Mdir obj_dir -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "run_sim: pass"
    exit 0
fi
echo "run_sim: fail"
exit 1
